// File: hw/dma_cfg.svh
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// Build-time sizing of the copy engine

// Byte address width on AR and AW
`define DMA_ADDR_W 32

// Data bus width in bits, one full-size beat per transfer
`define DMA_DATA_W 64

// Beats per INCR burst
// arlen and awlen carry this value minus one
`define DMA_BURST_LEN 16

// Entries in the beat FIFO between the two masters
// Must be a power of two
`define DMA_FIFO_DEPTH 8

`endif

// File: hw/dma_pkg.sv
`include "dma_cfg.svh"

package dma_pkg;

	// AXI field widths
	localparam int AXI_ID_W    = 4;
	localparam int AXI_LEN_W   = 8;
	localparam int AXI_SIZE_W  = 3;
	localparam int AXI_BURST_W = 2;
	localparam int AXI_CACHE_W = 4;
	localparam int AXI_PROT_W  = 3;
	localparam int AXI_RESP_W  = 2;
	localparam int AXI_STRB_W  = `DMA_DATA_W / 8;

	// Response encoding
	typedef logic [AXI_RESP_W-1:0] axi_resp_t;
	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	// Burst type, only INCR is issued
	typedef logic [AXI_BURST_W-1:0] axi_burst_t;
	localparam axi_burst_t BURST_INCR = 2'b01;

	// Fixed address-channel attributes
	localparam logic [AXI_LEN_W-1:0]   AXI_LEN_BURST = AXI_LEN_W'(`DMA_BURST_LEN - 1);
	localparam logic [AXI_SIZE_W-1:0]  AXI_SIZE_FULL = AXI_SIZE_W'($clog2(`DMA_DATA_W / 8));
	localparam logic [AXI_CACHE_W-1:0] AXI_CACHE_MOD = 4'h2;
	localparam logic [AXI_PROT_W-1:0]  AXI_PROT_NS   = 3'b010;

	// Host command, one copy of one burst
	typedef struct packed {
		logic [`DMA_ADDR_W-1:0] src;
		logic [`DMA_ADDR_W-1:0] dst;
	} copy_cmd_t;

	// Shared by AR and AW
	typedef struct packed {
		logic [AXI_ID_W-1:0]    id;
		logic [`DMA_ADDR_W-1:0] addr;
		logic [AXI_LEN_W-1:0]   len;
		logic [AXI_SIZE_W-1:0]  size;
		axi_burst_t             burst;
		logic [AXI_CACHE_W-1:0] cache;
		logic [AXI_PROT_W-1:0]  prot;
	} axi_addr_req_t;

	// Beat as stored in the FIFO
	typedef struct packed {
		logic [`DMA_DATA_W-1:0] data;
	} rd_beat_t;

	typedef struct packed {
		logic [`DMA_DATA_W-1:0] data;
		axi_resp_t              resp;
		logic                   last;
		logic [AXI_ID_W-1:0]    id;
	} axi_r_t;

	typedef struct packed {
		logic [`DMA_DATA_W-1:0] data;
		logic [AXI_STRB_W-1:0]  strb;
		logic                   last;
	} axi_w_t;

endpackage

// File: hw/dma_cmd_ctrl.sv
`timescale 1ns/10ps

`include "dma_cfg.svh"

module dma_cmd_ctrl import dma_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cmd_valid,
	input  copy_cmd_t              cmd,
	input  logic                   rd_done,
	input  logic                   rd_err,
	input  logic                   wr_done,
	input  logic                   wr_err,
	output logic                   busy,
	output logic                   done,
	output logic                   error,
	output logic                   rd_start,
	output logic                   wr_start,
	output logic [`DMA_ADDR_W-1:0] rd_addr,
	output logic [`DMA_ADDR_W-1:0] wr_addr
);

	copy_cmd_t cmd_q;
	logic      accept;
	logic      rd_seen;
	logic      wr_seen;
	logic      all_done;

	// Strobes while busy are dropped
	assign accept = cmd_valid & ~busy;

	// Stage pulses may arrive in either order
	assign all_done = busy & (rd_seen | rd_done) & (wr_seen | wr_done);

	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_q <= cmd;
		end
	end

	assign rd_addr = cmd_q.src;
	assign wr_addr = cmd_q.dst;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy     <= 1'b0;
			done     <= 1'b0;
			error    <= 1'b0;
			rd_start <= 1'b0;
			wr_start <= 1'b0;
			rd_seen  <= 1'b0;
			wr_seen  <= 1'b0;
		end else begin
			rd_start <= accept;
			wr_start <= accept;
			done     <= all_done;
			if (accept) begin
				busy    <= 1'b1;
				error   <= 1'b0;
				rd_seen <= 1'b0;
				wr_seen <= 1'b0;
			end else if (all_done) begin
				busy <= 1'b0;
			end else begin
				rd_seen <= rd_seen | rd_done;
				wr_seen <= wr_seen | wr_done;
			end
			// Sticky until the next accepted command
			if ((rd_done && rd_err) || (wr_done && wr_err)) begin
				error <= 1'b1;
			end
		end
	end

endmodule

// File: hw/dma_axi_rd.sv
`timescale 1ns/10ps

`include "dma_cfg.svh"

module dma_axi_rd import dma_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  logic [`DMA_ADDR_W-1:0] addr,
	output axi_addr_req_t          ar,
	output logic                   arvalid,
	input  logic                   arready,
	input  axi_r_t                 r,
	input  logic                   rvalid,
	output logic                   rready,
	output logic                   beat_valid,
	output rd_beat_t               beat,
	input  logic                   fifo_full,
	output logic                   finished,
	output logic                   err
);

	localparam int CNT_W = $clog2(`DMA_BURST_LEN);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_DATA
	} rd_state_t;

	rd_state_t        state;
	logic [CNT_W-1:0] cnt;
	logic             err_acc;
	logic             beat_fire;
	logic             last_beat;
	logic             beat_bad;

	// One full-width INCR burst
	always_comb begin
		ar.id    = '0;
		ar.addr  = addr;
		ar.len   = AXI_LEN_BURST;
		ar.size  = AXI_SIZE_FULL;
		ar.burst = BURST_INCR;
		ar.cache = AXI_CACHE_MOD;
		ar.prot  = AXI_PROT_NS;
	end

	assign arvalid = (state == ST_ADDR);

	// FIFO back-pressure stalls R directly
	assign rready    = (state == ST_DATA) & ~fifo_full;
	assign beat_fire = rvalid & rready;

	assign beat_valid = beat_fire;
	assign beat.data  = r.data;

	assign last_beat = (cnt == CNT_W'(`DMA_BURST_LEN - 1));

	// rlast has to line up with the beat count
	assign beat_bad = (r.last != last_beat) | (r.resp != RESP_OKAY);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= ST_IDLE;
			cnt      <= '0;
			err_acc  <= 1'b0;
			finished <= 1'b0;
			err      <= 1'b0;
		end else begin
			finished <= 1'b0;
			case (state)
				ST_IDLE: begin
					cnt     <= '0;
					err_acc <= 1'b0;
					if (start) begin
						state <= ST_ADDR;
					end
				end
				ST_ADDR: begin
					if (arready) begin
						state <= ST_DATA;
					end
				end
				ST_DATA: begin
					if (beat_fire) begin
						cnt     <= cnt + 1'b1;
						err_acc <= err_acc | beat_bad;
						if (last_beat) begin
							state    <= ST_IDLE;
							finished <= 1'b1;
							err      <= err_acc | beat_bad;
						end
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: hw/dma_beat_fifo.sv
`timescale 1ns/10ps

`include "dma_cfg.svh"

module dma_beat_fifo import dma_pkg::*; #(
	parameter type payload_t = rd_beat_t
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     push,
	input  payload_t din,
	input  logic     pop,
	output payload_t dout,
	output logic     full,
	output logic     empty
);

	localparam int AW = $clog2(`DMA_FIFO_DEPTH);

	payload_t    mem [`DMA_FIFO_DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        do_push;
	logic        do_pop;

	// Extra pointer bit tells full from empty
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign do_pop  = pop & ~empty;
	// A pop frees the slot for a push in the same cycle
	assign do_push = push & (~full | do_pop);

	assign dout = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr[AW-1:0]] <= din;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

// File: hw/dma_axi_wr.sv
`timescale 1ns/10ps

`include "dma_cfg.svh"

module dma_axi_wr import dma_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  logic [`DMA_ADDR_W-1:0] addr,
	output axi_addr_req_t          aw,
	output logic                   awvalid,
	input  logic                   awready,
	output axi_w_t                 w,
	output logic                   wvalid,
	input  logic                   wready,
	input  axi_resp_t              bresp,
	input  logic                   bvalid,
	output logic                   bready,
	input  rd_beat_t               fifo_dout,
	input  logic                   fifo_empty,
	output logic                   fifo_pop,
	output logic                   finished,
	output logic                   err
);

	localparam int CNT_W = $clog2(`DMA_BURST_LEN);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_DATA,
		ST_RESP
	} wr_state_t;

	wr_state_t        state;
	logic [CNT_W-1:0] cnt;
	logic             last_beat;

	always_comb begin
		aw.id    = '0;
		aw.addr  = addr;
		aw.len   = AXI_LEN_BURST;
		aw.size  = AXI_SIZE_FULL;
		aw.burst = BURST_INCR;
		aw.cache = AXI_CACHE_MOD;
		aw.prot  = AXI_PROT_NS;
	end

	assign awvalid = (state == ST_ADDR);

	assign last_beat = (cnt == CNT_W'(`DMA_BURST_LEN - 1));

	// Head of the FIFO goes straight onto W
	// It only moves on a handshake, so the payload holds while stalled
	assign wvalid = (state == ST_DATA) & ~fifo_empty;
	assign w.data = fifo_dout.data;
	assign w.strb = '1;
	assign w.last = last_beat;

	assign fifo_pop = wvalid & wready;

	assign bready = (state == ST_RESP);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= ST_IDLE;
			cnt      <= '0;
			finished <= 1'b0;
			err      <= 1'b0;
		end else begin
			finished <= 1'b0;
			case (state)
				ST_IDLE: begin
					cnt <= '0;
					if (start) begin
						state <= ST_ADDR;
					end
				end
				ST_ADDR: begin
					if (awready) begin
						state <= ST_DATA;
					end
				end
				ST_DATA: begin
					if (fifo_pop) begin
						cnt <= cnt + 1'b1;
						if (last_beat) begin
							state <= ST_RESP;
						end
					end
				end
				ST_RESP: begin
					if (bvalid) begin
						state    <= ST_IDLE;
						finished <= 1'b1;
						err      <= (bresp != RESP_OKAY);
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: hw/dma_copy_top.sv
`timescale 1ns/10ps

`include "dma_cfg.svh"

module dma_copy_top import dma_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	// Host strobes
	input  logic          cmd_valid,
	input  copy_cmd_t     cmd,
	output logic          busy,
	output logic          done,
	output logic          error,
	// Read address and data
	output axi_addr_req_t ar,
	output logic          arvalid,
	input  logic          arready,
	input  axi_r_t        r,
	input  logic          rvalid,
	output logic          rready,
	// Write address, data and response
	output axi_addr_req_t aw,
	output logic          awvalid,
	input  logic          awready,
	output axi_w_t        w,
	output logic          wvalid,
	input  logic          wready,
	input  axi_resp_t     bresp,
	input  logic          bvalid,
	output logic          bready
);

	logic                   rd_start;
	logic                   wr_start;
	logic [`DMA_ADDR_W-1:0] rd_addr;
	logic [`DMA_ADDR_W-1:0] wr_addr;
	logic                   rd_done;
	logic                   rd_err;
	logic                   wr_done;
	logic                   wr_err;
	logic                   beat_valid;
	rd_beat_t               beat;
	rd_beat_t               fifo_dout;
	logic                   fifo_full;
	logic                   fifo_empty;
	logic                   fifo_pop;

	dma_cmd_ctrl dma_cmd_ctrl_i (
		.clk(clk), .rst(rst),
		.cmd_valid(cmd_valid), .cmd(cmd),
		.rd_done(rd_done), .rd_err(rd_err),
		.wr_done(wr_done), .wr_err(wr_err),
		.busy(busy), .done(done), .error(error),
		.rd_start(rd_start), .wr_start(wr_start),
		.rd_addr(rd_addr), .wr_addr(wr_addr)
	);

	dma_axi_rd dma_axi_rd_i (
		.clk(clk), .rst(rst),
		.start(rd_start), .addr(rd_addr),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready),
		.beat_valid(beat_valid), .beat(beat), .fifo_full(fifo_full),
		.finished(rd_done), .err(rd_err)
	);

	dma_beat_fifo #(
		.payload_t(rd_beat_t)
	) dma_beat_fifo_i (
		.clk(clk), .rst(rst),
		.push(beat_valid), .din(beat),
		.pop(fifo_pop), .dout(fifo_dout),
		.full(fifo_full), .empty(fifo_empty)
	);

	dma_axi_wr dma_axi_wr_i (
		.clk(clk), .rst(rst),
		.start(wr_start), .addr(wr_addr),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.fifo_dout(fifo_dout), .fifo_empty(fifo_empty), .fifo_pop(fifo_pop),
		.finished(wr_done), .err(wr_err)
	);

endmodule

// File: tests/dma_checker.sv
`timescale 1ns/10ps

`include "dma_cfg.svh"

module dma_checker import dma_pkg::*; (
	input logic          clk,
	input logic          rst,
	input logic          cmd_valid,
	input logic          busy,
	input logic          done,
	input logic          error,
	input axi_addr_req_t ar,
	input logic          arvalid,
	input logic          arready,
	input logic          rvalid,
	input logic          rready,
	input axi_addr_req_t aw,
	input logic          awvalid,
	input logic          awready,
	input axi_w_t        w,
	input logic          wvalid,
	input logic          wready,
	input logic          bready
);

	localparam int LEN   = `DMA_BURST_LEN;
	localparam int DEPTH = `DMA_FIFO_DEPTH;

	int unsigned fail_count = 0;
	logic        seen_cmd;
	logic        pending;
	logic        ar_taken;
	logic [7:0]  w_cnt;
	logic [7:0]  occ;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			seen_cmd <= 1'b0;
			pending  <= 1'b0;
			ar_taken <= 1'b0;
			w_cnt    <= '0;
			occ      <= '0;
		end else begin
			seen_cmd <= seen_cmd | cmd_valid;
			if (cmd_valid && !busy) begin
				pending  <= 1'b1;
				ar_taken <= 1'b0;
			end else begin
				pending  <= pending & ~done;
				ar_taken <= ar_taken | (arvalid & arready);
			end
			// W beat index within the current burst
			if (awvalid && awready) begin
				w_cnt <= '0;
			end else if (wvalid && wready) begin
				w_cnt <= w_cnt + 8'd1;
			end
			// Beats taken on R and not yet sent on W
			if ((rvalid && rready) && !(wvalid && wready)) begin
				occ <= occ + 8'd1;
			end else if (!(rvalid && rready) && (wvalid && wready)) begin
				occ <= occ - 8'd1;
			end
		end
	end

	// Quiet from reset until the first command
	assert property (@(posedge clk)
		!seen_cmd |-> !(busy || done || error || arvalid || rready || awvalid || wvalid || bready))
	else begin
		fail_count++;
		$error("host or AXI output active before the first command");
	end

	// A valid waits for its ready with the payload held
	assert property (@(posedge clk) disable iff (rst)
		(!$past(arvalid && !arready) || (arvalid && $stable(ar))) &&
		(!$past(awvalid && !awready) || (awvalid && $stable(aw))) &&
		(!$past(wvalid && !wready) || (wvalid && $stable(w))))
	else begin
		fail_count++;
		$error("valid dropped or payload changed before ready");
	end

	// Fixed INCR burst of LEN beats on AR and AW
	assert property (@(posedge clk) disable iff (rst)
		(!arvalid || (ar.len == 8'(LEN - 1) && ar.burst == 2'b01)) &&
		(!awvalid || (aw.len == 8'(LEN - 1) && aw.burst == 2'b01)))
	else begin
		fail_count++;
		$error("burst length or burst type wrong on an address channel");
	end

	// R pauses with DEPTH beats buffered, W never sends a beat not yet read
	assert property (@(posedge clk) disable iff (rst)
		(!(rvalid && rready) || occ < 8'(DEPTH)) &&
		(!(wvalid && wready) || occ != 8'd0) &&
		(!wvalid || (w.last == (w_cnt == 8'(LEN - 1)))))
	else begin
		fail_count++;
		$error("beat flow through the FIFO or wlast position wrong");
	end

	// One AR and one done per accepted command, error cleared on accept
	assert property (@(posedge clk) disable iff (rst)
		(!(arvalid && arready) || !ar_taken) &&
		(!done || pending) &&
		(!$past(cmd_valid && !busy) || !error))
	else begin
		fail_count++;
		$error("command accounting broken");
	end

endmodule

bind dma_copy_top dma_checker dma_checker_i (.*);

// File: tests/dma_tb.sv
`timescale 1ns/10ps

`include "dma_cfg.svh"

module dma_tb import dma_pkg::*; ();

	localparam int LEN       = `DMA_BURST_LEN;
	localparam int MEM_WORDS = 1024;

	logic          clk       = 1'b0;
	logic          rst       = 1'b1;
	logic          cmd_valid = 1'b0;
	copy_cmd_t     cmd       = '0;
	logic          busy;
	logic          done;
	logic          error;
	axi_addr_req_t ar;
	logic          arvalid;
	logic          arready   = 1'b0;
	axi_r_t        r         = '0;
	logic          rvalid    = 1'b0;
	logic          rready;
	axi_addr_req_t aw;
	logic          awvalid;
	logic          awready   = 1'b0;
	axi_w_t        w;
	logic          wvalid;
	logic          wready    = 1'b0;
	axi_resp_t     bresp     = 2'b00;
	logic          bvalid    = 1'b0;
	logic          bready;

	// Slave memory and burst state
	logic [`DMA_DATA_W-1:0] mem [MEM_WORDS];
	int   r_base;
	int   r_cnt;
	logic r_act;
	logic r_fire;
	int   w_base;
	int   w_cnt;
	logic b_pend;
	logic b_fire;
	int   w_stall   = 0;
	logic drop_last = 1'b0;
	logic slverr_rd = 1'b0;

	dma_copy_top dma_copy_top_i (.*);

	initial begin
		forever #20 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("Done: errors found");
		$fatal(1, "%s", why);
	endtask

	// Handshakes are taken at the rising edge
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= {$urandom, $urandom};
			end
			r_act  <= 1'b0;
			r_fire <= 1'b0;
			r_base <= 0;
			r_cnt  <= 0;
			w_base <= 0;
			w_cnt  <= 0;
			b_pend <= 1'b0;
			b_fire <= 1'b0;
		end else begin
			r_fire <= rvalid && rready;
			b_fire <= bvalid && bready;
			if (arvalid && arready) begin
				r_base <= int'(ar.addr[12:3]);
				r_cnt  <= 0;
				r_act  <= 1'b1;
			end
			if (rvalid && rready) begin
				r_cnt <= r_cnt + 1;
				if (r_cnt == LEN - 1) begin
					r_act <= 1'b0;
				end
			end
			if (awvalid && awready) begin
				w_base <= int'(aw.addr[12:3]);
				w_cnt  <= 0;
			end
			if (wvalid && wready) begin
				mem[w_base + w_cnt] <= w.data;
				w_cnt <= w_cnt + 1;
				if (w.last) begin
					b_pend <= 1'b1;
				end
			end
			if (bvalid && bready) begin
				b_pend <= 1'b0;
			end
		end
	end

	// Slave outputs change on the falling edge
	always @(negedge clk) begin
		arready = ($urandom_range(0, 3) == 0);
		awready = ($urandom_range(0, 3) == 0);
		if (w_stall != 0) begin
			wready  = 1'b0;
			w_stall = w_stall - 1;
		end else begin
			wready = ($urandom_range(0, 1) == 1);
			// Long stall, the reader fills the FIFO meanwhile
			if ($urandom_range(0, 9) == 0) begin
				w_stall = $urandom_range(12, 30);
			end
		end
		if (!rvalid || r_fire) begin
			rvalid = r_act && ($urandom_range(0, 3) != 0);
			r.data = mem[r_base + r_cnt];
			r.resp = (slverr_rd && r_cnt == 5) ? 2'b10 : 2'b00;
			r.last = (r_cnt == LEN - 1) && !drop_last;
			r.id   = '0;
		end
		if (!bvalid || b_fire) begin
			bvalid = b_pend && ($urandom_range(0, 1) == 1);
		end
	end

	always @(negedge clk) begin
		if (dma_copy_top_i.dma_checker_i.fail_count != 0) begin
			abort_run("a bound protocol assertion failed");
		end
	end

	task automatic run_copy(input logic lose_last, input logic rd_slverr, input logic poke_busy);
		int src_w;
		int dst_w;
		int waited;
		// Source and destination never overlap
		src_w     = $urandom_range(0, 511 - LEN);
		dst_w     = $urandom_range(512, MEM_WORDS - 1 - LEN);
		drop_last = lose_last;
		slverr_rd = rd_slverr;
		@(negedge clk);
		cmd_valid = 1'b1;
		cmd.src   = 32'(src_w * 8);
		cmd.dst   = 32'(dst_w * 8);
		@(negedge clk);
		if (poke_busy) begin
			// Second strobe right behind the accepted one, before AR goes out
			assert (busy) else abort_run("busy did not rise after an accepted command");
			cmd.src = 32'((src_w + LEN) * 8);
			@(negedge clk);
		end
		cmd_valid = 1'b0;
		waited = 0;
		while (!done) begin
			@(negedge clk);
			waited++;
			if (waited > 4000) begin
				abort_run("timed out waiting for done");
			end
		end
		assert (error == (lose_last || rd_slverr))
		else begin
			$display("FAILED at %0t: error level %b, expected %b", $time, error,
				lose_last || rd_slverr);
			abort_run("wrong error level after done");
		end
		for (int i = 0; i < LEN; i++) begin
			assert (mem[dst_w + i] == mem[src_w + i])
			else begin
				$display("FAILED at %0t: copy word %0d is %h, expected %h", $time, i,
					mem[dst_w + i], mem[src_w + i]);
				abort_run("copied data mismatch");
			end
		end
		drop_last = 1'b0;
		slverr_rd = 1'b0;
	endtask

	initial begin
		void'($urandom(32'h72bd_53ad));
		repeat (16) @(negedge clk);
		rst = 1'b0;
		// Idle stretch before the first command
		repeat (8) @(negedge clk);
		run_copy(1'b0, 1'b0, 1'b0);
		run_copy(1'b0, 1'b0, 1'b1);
		run_copy(1'b1, 1'b0, 1'b0);
		run_copy(1'b0, 1'b0, 1'b0);
		run_copy(1'b0, 1'b1, 1'b1);
		run_copy(1'b0, 1'b0, 1'b0);
		repeat (10) @(negedge clk);
		if (dma_copy_top_i.dma_checker_i.fail_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			abort_run("bound protocol assertions failed");
		end
	end

endmodule

// File: verilog.f
+incdir+hw
hw/dma_pkg.sv
hw/dma_cmd_ctrl.sv
hw/dma_axi_rd.sv
hw/dma_beat_fifo.sv
hw/dma_axi_wr.sv
hw/dma_copy_top.sv
tests/dma_checker.sv
tests/dma_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = dma_tb
FILELIST  = verilog.f
SIMFLAGS  = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIMFLAGS)

clean:
	rm -rf obj_dir
